// ==== byteRam.sv ====
module byteRam #(
    parameter int RamAddrWidth = 12
) (
    input  logic            clk,
    input  logic            rdy,
    input  memPkg::memReq_t ramReq,
    output memPkg::byte_t   ramRdata
);

    memPkg::byte_t mem [2**RamAddrWidth];

    logic [RamAddrWidth-1:0] idx;

    // only the low address bits reach the array
    assign idx = ramReq.addr[RamAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (rdy && ramReq.valid) begin
            if (ramReq.write) begin
                mem[idx] <= ramReq.wdata;
            end else begin
                ramRdata <= mem[idx];
            end
        end
    end

endmodule

// ==== dataSequencer.sv ====
module dataSequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            dataEn,
    input  logic            dataWrite,
    input  memPkg::len_t    dataLen,
    input  memPkg::addr_t   dataAddr,
    input  memPkg::word_t   dataWdata,
    input  logic            grant,
    input  memPkg::byte_t   rdata,
    output memPkg::memReq_t req,
    output logic            last,
    output logic            dataDone,
    output memPkg::word_t   dataRdata
);

    typedef enum logic [1:0] {
        Idle,
        Load,
        LoadFinish,
        Store
    } dataState_t;

    dataState_t    state;
    memPkg::len_t  cnt;
    logic          pending;
    logic [1:0]    pendIdx;
    memPkg::word_t loadWord;

    always_comb begin
        req.valid = dataEn && (state != LoadFinish);
        req.write = dataWrite;
        req.addr  = dataAddr + memPkg::addr_t'(cnt);
        req.wdata = dataWdata[cnt[1:0]*8 +: 8];
    end

    assign last = grant && ((cnt + 3'd1) == dataLen);

    // stores finish on the last write and loads one cycle later
    assign dataDone = (rdy && (state == LoadFinish)) || (last && dataWrite);

    // merge the byte still on the RAM output
    always_comb begin
        dataRdata = loadWord;
        if (pending) begin
            dataRdata[pendIdx*8 +: 8] = rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= Idle;
            cnt     <= '0;
            pending <= 1'b0;
        end else if (rdy) begin
            pending <= grant && !dataWrite;
            if (grant) begin
                if (last) begin
                    cnt   <= '0;
                    state <= dataWrite ? Idle : LoadFinish;
                end else begin
                    cnt   <= cnt + 3'd1;
                    state <= dataWrite ? Store : Load;
                end
            end else if (state == LoadFinish) begin
                state <= Idle;
            end
        end
    end

    // upper bytes stay zero for short loads
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (grant) begin
                pendIdx <= cnt[1:0];
            end
            if (state == Idle) begin
                loadWord <= '0;
            end else if (pending) begin
                loadWord[pendIdx*8 +: 8] <= rdata;
            end
        end
    end

    legalLen: assert property (
        @(posedge clk) disable iff (rst)
        dataEn |-> (dataLen inside {3'd1, 3'd2, 3'd4})
    );

    // the access type holds while the access runs
    opHeld: assert property (
        @(posedge clk) disable iff (rst)
        (state != Idle) |-> (dataWrite == (state == Store))
    );

endmodule

// ==== fetchSequencer.sv ====
module fetchSequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            fetchEn,
    input  memPkg::addr_t   fetchAddr,
    input  logic            grant,
    input  memPkg::byte_t   rdata,
    output memPkg::memReq_t req,
    output logic            last,
    output logic            fetchDone,
    output memPkg::word_t   fetchInst
);

    typedef enum logic [1:0] {
        Idle,
        Issue,
        Finish
    } fetchState_t;

    fetchState_t   state;
    logic [1:0]    cnt;
    logic          pending;
    memPkg::word_t inst;

    // one byte read per granted cycle, in address order
    always_comb begin
        req.valid = fetchEn && (state != Finish);
        req.write = 1'b0;
        req.addr  = fetchAddr + memPkg::addr_t'(cnt);
        req.wdata = '0;
    end

    assign last = grant && (cnt == 2'd3);

    // byte 3 comes straight from the RAM in the finish cycle
    assign fetchDone = rdy && (state == Finish);
    assign fetchInst = {rdata, inst[31:8]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= Idle;
            cnt     <= '0;
            pending <= 1'b0;
        end else if (rdy) begin
            pending <= grant;
            if (grant) begin
                cnt   <= cnt + 2'd1;
                state <= last ? Finish : Issue;
            end else if (state == Finish) begin
                state <= Idle;
            end
        end
    end

    // little endian, newest byte enters at the top
    always_ff @(posedge clk) begin
        if (rdy && pending) begin
            inst <= {rdata, inst[31:8]};
        end
    end

    addrStable: assert property (
        @(posedge clk) disable iff (rst)
        (state != Idle) |-> $stable(fetchAddr)
    );

endmodule

// ==== memPkg.sv ====
package memPkg;

    // one RAM byte
    typedef logic [7:0] byte_t;

    // instruction or data word
    typedef logic [31:0] word_t;

    // byte address as the core sees it
    typedef logic [31:0] addr_t;

    // access length in bytes, 1, 2 or 4
    typedef logic [2:0] len_t;

    // one byte transfer on the RAM port
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        byte_t wdata;
    } memReq_t;

endpackage

// ==== memSubsystem.f ====
memPkg.sv
byteRam.sv
fetchSequencer.sv
dataSequencer.sv
ramArbiter.sv
memSubsystem.sv
tbClock.sv
memSubsystemTb.sv

// ==== memSubsystem.sv ====
module memSubsystem #(
    parameter int RamAddrWidth = 12
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,
    input  logic          fetchEn,
    input  memPkg::addr_t fetchAddr,
    input  logic          dataEn,
    input  logic          dataWrite,
    input  memPkg::len_t  dataLen,
    input  memPkg::addr_t dataAddr,
    input  memPkg::word_t dataWdata,
    output logic          fetchDone,
    output memPkg::word_t fetchInst,
    output logic          dataDone,
    output memPkg::word_t dataRdata
);

    memPkg::memReq_t fetchReq;
    memPkg::memReq_t dataReq;
    memPkg::memReq_t ramReq;
    memPkg::byte_t   ramRdata;
    memPkg::byte_t   rdataOut;
    logic            fetchGrant;
    logic            dataGrant;
    logic            fetchLast;
    logic            dataLast;

    fetchSequencer i_fetchSequencer (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .grant     (fetchGrant),
        .rdata     (rdataOut),
        .req       (fetchReq),
        .last      (fetchLast),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst)
    );

    dataSequencer i_dataSequencer (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .dataEn    (dataEn),
        .dataWrite (dataWrite),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .grant     (dataGrant),
        .rdata     (rdataOut),
        .req       (dataReq),
        .last      (dataLast),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

    ramArbiter i_ramArbiter (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .fetchReq   (fetchReq),
        .dataReq    (dataReq),
        .fetchLast  (fetchLast),
        .dataLast   (dataLast),
        .ramRdata   (ramRdata),
        .fetchGrant (fetchGrant),
        .dataGrant  (dataGrant),
        .ramReq     (ramReq),
        .rdataOut   (rdataOut)
    );

    byteRam #(
        .RamAddrWidth (RamAddrWidth)
    ) i_byteRam (
        .clk      (clk),
        .rdy      (rdy),
        .ramReq   (ramReq),
        .ramRdata (ramRdata)
    );

endmodule

// ==== memSubsystemTb.sv ====
module memSubsystemTb;

    localparam int RamAddrWidth = 12;
    localparam int MaxWait = 100;

    logic          clk;
    logic          rst;
    logic          rdy;
    logic          fetchEn;
    memPkg::addr_t fetchAddr;
    logic          dataEn;
    logic          dataWrite;
    memPkg::len_t  dataLen;
    memPkg::addr_t dataAddr;
    memPkg::word_t dataWdata;
    logic          fetchDone;
    memPkg::word_t fetchInst;
    logic          dataDone;
    memPkg::word_t dataRdata;

    memPkg::byte_t shadow [2**RamAddrWidth];
    memPkg::word_t expLoad;
    memPkg::word_t expInst;
    logic          pauseOn;

    tbClock i_tbClock (.clk (clk));

    memSubsystem #(.RamAddrWidth (RamAddrWidth)) i_memSubsystem (.*);

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    quietReset: assert property (@(posedge clk) $past(rst) |-> !fetchDone && !dataDone)
        else stopRun($sformatf("a done strobe pulsed during reset at %0t", $time));

    loadCheck: assert property (@(posedge clk) disable iff (rst)
        (dataDone && !dataWrite) |-> dataRdata == expLoad)
        else stopRun($sformatf("FAILED at %0t: dataRdata expected %h, got %h",
            $time, $sampled(expLoad), $sampled(dataRdata)));

    fetchCheck: assert property (@(posedge clk) disable iff (rst)
        fetchDone |-> fetchInst == expInst)
        else stopRun($sformatf("FAILED at %0t: fetchInst expected %h, got %h",
            $time, $sampled(expInst), $sampled(fetchInst)));

    pauseCheck: assert property (@(posedge clk) disable iff (rst)
        !rdy |-> !fetchDone && !dataDone)
        else stopRun($sformatf("a done strobe pulsed while rdy was low at %0t", $time));

    // random pauses only when enabled
    initial begin
        rdy = 1'b1;
        forever begin
            @(posedge clk);
            rdy <= pauseOn ? (($urandom % 4) != 0) : 1'b1;
        end
    end

    // low address bits, wrapping like the RAM
    function automatic logic [RamAddrWidth-1:0] ramIdx(memPkg::addr_t a, int i);
        memPkg::addr_t s;
        s = a + memPkg::addr_t'(i);
        return s[RamAddrWidth-1:0];
    endfunction

    function automatic memPkg::word_t shadowWord(memPkg::addr_t a, memPkg::len_t len);
        memPkg::word_t w;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            w[i*8 +: 8] = shadow[ramIdx(a, i)];
        end
        return w;
    endfunction

    function automatic memPkg::len_t pickLen(int k);
        case (k % 3)
            0: return 3'd1;
            1: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    task automatic waitDataDone(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!dataDone && n < MaxWait);
        if (!dataDone) begin
            stopRun({"the data ", what, " never finished"});
        end
        dataEn <= 1'b0;
    endtask

    task automatic storeBytes(input memPkg::addr_t a, input memPkg::len_t len);
        memPkg::word_t w;
        w = $urandom;
        for (int i = 0; i < int'(len); i++) begin
            shadow[ramIdx(a, i)] = w[i*8 +: 8];
        end
        @(posedge clk);
        dataAddr  <= a;
        dataLen   <= len;
        dataWdata <= w;
        dataWrite <= 1'b1;
        dataEn    <= 1'b1;
        waitDataDone("store");
    endtask

    task automatic loadBytes(input memPkg::addr_t a, input memPkg::len_t len);
        @(posedge clk);
        expLoad   <= shadowWord(a, len);
        dataAddr  <= a;
        dataLen   <= len;
        dataWrite <= 1'b0;
        dataEn    <= 1'b1;
        waitDataDone("load");
    endtask

    task automatic fetchWord(input memPkg::addr_t a, input logic timed);
        int n;
        @(posedge clk);
        expInst   <= shadowWord(a, 3'd4);
        fetchAddr <= a;
        fetchEn   <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!fetchDone && n < MaxWait);
        if (!fetchDone) begin
            stopRun("the instruction fetch never finished");
        end
        fetchEn <= 1'b0;
        if (timed) begin
            latency: assert (n == 5)
                else stopRun($sformatf("FAILED at %0t: fetchDone latency expected 5, got %0d",
                    $time, n));
        end
    endtask

    // fetch and load requested in the same cycle
    task automatic raceFetchLoad(input memPkg::addr_t fa, input memPkg::addr_t da,
                                 input memPkg::len_t len);
        int n;
        int dataAt;
        int fetchAt;
        @(posedge clk);
        expInst   <= shadowWord(fa, 3'd4);
        expLoad   <= shadowWord(da, len);
        fetchAddr <= fa;
        fetchEn   <= 1'b1;
        dataAddr  <= da;
        dataLen   <= len;
        dataWrite <= 1'b0;
        dataEn    <= 1'b1;
        n = 0;
        dataAt = 0;
        fetchAt = 0;
        while ((dataAt == 0 || fetchAt == 0) && n < MaxWait) begin
            @(posedge clk);
            n++;
            if (dataDone) begin
                dataAt = n;
                dataEn <= 1'b0;
            end
            if (fetchDone) begin
                fetchAt = n;
                fetchEn <= 1'b0;
            end
        end
        if (dataAt == 0 || fetchAt == 0) begin
            stopRun("the fetch or the load started together never finished");
        end
        dataFirst: assert (dataAt < fetchAt)
            else stopRun("dataDone did not come before fetchDone");
    endtask

    task automatic testRound(input logic timed);
        memPkg::addr_t a;
        memPkg::addr_t b;
        memPkg::len_t  len;
        for (int k = 0; k < 6; k++) begin
            a = $urandom;
            len = pickLen(k);
            storeBytes(a, len);
            loadBytes(a, len);
        end
        a = $urandom;
        storeBytes(a, 3'd4);
        fetchWord(a, timed);
        b = $urandom;
        len = pickLen(int'($urandom % 3));
        storeBytes(b, len);
        raceFetchLoad(a, b, len);
    endtask

    initial begin
        void'($urandom(31));
        rst       = 1'b1;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        dataEn    = 1'b0;
        dataWrite = 1'b0;
        dataLen   = 3'd4;
        dataAddr  = '0;
        dataWdata = '0;
        pauseOn   = 1'b0;
        expLoad   = '0;
        expInst   = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        testRound(1'b1);
        pauseOn <= 1'b1;
        repeat (3) testRound(1'b0);
        pauseOn <= 1'b0;
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== ramArbiter.sv ====
module ramArbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  memPkg::memReq_t fetchReq,
    input  memPkg::memReq_t dataReq,
    input  logic            fetchLast,
    input  logic            dataLast,
    input  memPkg::byte_t   ramRdata,
    output logic            fetchGrant,
    output logic            dataGrant,
    output memPkg::memReq_t ramReq,
    output memPkg::byte_t   rdataOut
);

    typedef enum logic [1:0] {
        OwnNone,
        OwnFetch,
        OwnData
    } owner_t;

    owner_t owner;

    // data goes first unless an owner holds the lock
    always_comb begin
        fetchGrant = 1'b0;
        dataGrant  = 1'b0;
        if (rdy) begin
            case (owner)
                OwnFetch: fetchGrant = fetchReq.valid;
                OwnData:  dataGrant  = dataReq.valid;
                default: begin
                    if (dataReq.valid) begin
                        dataGrant = 1'b1;
                    end else begin
                        fetchGrant = fetchReq.valid;
                    end
                end
            endcase
        end
    end

    always_comb begin
        ramReq = '0;
        if (dataGrant) begin
            ramReq = dataReq;
        end else if (fetchGrant) begin
            ramReq = fetchReq;
        end
    end

    // both sequencers see the byte and pick their own
    assign rdataOut = ramRdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OwnNone;
        end else if (dataGrant) begin
            owner <= dataLast ? OwnNone : OwnData;
        end else if (fetchGrant) begin
            owner <= fetchLast ? OwnNone : OwnFetch;
        end
    end

    // a locked owner keeps requesting until its last byte
    lockHeld: assert property (
        @(posedge clk) disable iff (rst)
        ((owner != OwnFetch) || fetchReq.valid) && ((owner != OwnData) || dataReq.valid)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, the fail message in sim.log marks a failed run
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module memSubsystemTb -f memSubsystem.f \
    && ./obj_dir/VmemSubsystemTb > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// ==== tbClock.sv ====
module tbClock #(
    parameter int Period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(Period / 2) clk = ~clk;
        end
    end

endmodule
